/* common/float_pkg.sv */
// float field widths and packed float struct

`default_nettype none

`include "raster_settings.svh"

package float_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------

    localparam int EXP_W  = `RS_EXP_WIDTH;
    localparam int FRAC_W = `RS_FRAC_WIDTH;

    // ----------------------------------------
    // packed float
    // ----------------------------------------

    // sign, biased exponent, fraction without hidden bit
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } float_t;

endpackage

`default_nettype wire

/* common/raster_settings.svh */
// global sizing macros for the span interpolator

`ifndef RASTER_SETTINGS_SVH
`define RASTER_SETTINGS_SVH

// ----------------------------------------
// float format
// ----------------------------------------

// single precision layout
`define RS_EXP_WIDTH    8
`define RS_FRAC_WIDTH   23

// ----------------------------------------
// span geometry
// ----------------------------------------

// interpolated channels, e.g. depth and one texture coordinate
`define RS_NUM_CH       2

// span length and pixel index
`define RS_LEN_WIDTH    8

`endif

/* common/span_pkg.sv */
// register map, config write, span item, sideband and pixel output types

`default_nettype none

`include "raster_settings.svh"

package span_pkg;

    import float_pkg::*;

    localparam int CFG_ADDR_W = 4;
    localparam int CFG_DATA_W = 32;

    // ----------------------------------------
    // register map
    // ----------------------------------------

    localparam logic [CFG_ADDR_W-1:0] ADDR_CTRL    = 4'd0;
    localparam logic [CFG_ADDR_W-1:0] ADDR_LEN     = 4'd1;
    // per channel: initial at base + 2c, step at base + 2c + 1
    localparam logic [CFG_ADDR_W-1:0] ADDR_CH_BASE = 4'd2;

    function automatic logic [CFG_ADDR_W-1:0] init_addr(input int ch);
        return CFG_ADDR_W'(ADDR_CH_BASE + 2 * ch);
    endfunction

    function automatic logic [CFG_ADDR_W-1:0] step_addr(input int ch);
        return CFG_ADDR_W'(ADDR_CH_BASE + 2 * ch + 1);
    endfunction

    // ----------------------------------------
    // structs
    // ----------------------------------------

    typedef struct packed {
        logic                  valid;
        logic [CFG_ADDR_W-1:0] addr;
        logic [CFG_DATA_W-1:0] data;
    } cfg_wr_t;

    typedef struct packed {
        float_t [`RS_NUM_CH-1:0]   init;
        float_t [`RS_NUM_CH-1:0]   step;
        logic [`RS_LEN_WIDTH-1:0] length;
    } span_cfg_t;

    typedef struct packed {
        logic valid;
        logic is_initial;
        logic is_increment;
    } step_cmd_t;

    typedef struct packed {
        logic [`RS_LEN_WIDTH-1:0] index;
        logic                     last;
    } pix_tag_t;

    typedef struct packed {
        logic                    valid;
        pix_tag_t                tag;
        float_t [`RS_NUM_CH-1:0] value;
    } pix_out_t;

endpackage

`default_nettype wire

/* float_span_unit.f */
+incdir+common
common/float_pkg.sv
common/span_pkg.sv
float_step/float_step.sv
float_step/stage_valid_ctrl.sv
logic/span_regs.sv
logic/span_sequencer.sv
logic/float_span_unit.sv
verification/tb_float_span_unit.sv

/* float_step/float_step.sv */
// six-stage float step core: load an initial value, then add a step per item

`default_nettype none

module float_step
    import float_pkg::*;
(
    input  logic       clk,
    input  logic [5:0] stage_cke,
    input  float_t     init,
    input  float_t     step,
    input  logic       is_initial,
    input  logic       is_increment,
    output float_t     data
);

    logic                     st0_init_sign;
    logic [EXP_W-1:0]         st0_exp;
    logic [EXP_W-1:0]         st0_init_shift;
    logic [FRAC_W-1:0]        st0_init_frac;
    logic                     st0_step_sign;
    logic [EXP_W-1:0]         st0_step_shift;
    logic [FRAC_W-1:0]        st0_step_frac;
    logic                     st0_initial;
    logic                     st0_increment;

    logic                     st1_init_sign;
    logic [EXP_W-1:0]         st1_exp;
    logic [FRAC_W:0]          st1_init_frac;
    logic                     st1_step_sign;
    logic [FRAC_W:0]          st1_step_frac;
    logic                     st1_initial;
    logic                     st1_increment;

    // accumulator, kept in two's complement
    logic                     st2_base_sign;
    logic [EXP_W-1:0]         st2_base_exp;
    logic signed [FRAC_W+2:0] st2_base_frac;
    logic signed [FRAC_W+1:0] st2_step_frac;
    logic                     st2_shift;
    logic signed [FRAC_W+1:0] st2_step_adj;
    logic signed [FRAC_W+2:0] st2_inc_frac;
    logic signed [FRAC_W+2:0] st2_norm;
    logic signed [FRAC_W+2:0] st2_mag;

    logic                     st3_sign;
    logic [EXP_W-1:0]         st3_exp;
    logic [FRAC_W:0]          st3_frac;
    logic [EXP_W-1:0]         st3_lz;

    logic                     st4_sign;
    logic [EXP_W-1:0]         st4_exp;
    logic [FRAC_W:0]          st4_frac;
    logic [EXP_W-1:0]         st4_shift;
    logic [FRAC_W:0]          st4_norm;

    logic                     st5_sign;
    logic [EXP_W-1:0]         st5_exp;
    logic [FRAC_W-1:0]        st5_frac;

    // stage 0: pick the larger exponent
    always_ff @(posedge clk) begin
        if (stage_cke[0]) begin
            st0_init_sign <= init.sign;
            st0_init_frac <= init.frac;
            st0_step_sign <= step.sign;
            st0_step_frac <= step.frac;
            if (init.exp >= step.exp) begin
                st0_exp        <= init.exp;
                st0_init_shift <= '0;
                st0_step_shift <= init.exp - step.exp;
            end else begin
                st0_exp        <= step.exp;
                st0_init_shift <= step.exp - init.exp;
                st0_step_shift <= '0;
            end
            st0_initial   <= is_initial;
            st0_increment <= is_increment;
        end
    end

    // stage 1: align mantissas
    always_ff @(posedge clk) begin
        if (stage_cke[1]) begin
            st1_init_sign <= st0_init_sign;
            st1_exp       <= st0_exp;
            st1_init_frac <= {1'b1, st0_init_frac} >> st0_init_shift;
            st1_step_sign <= st0_step_sign;
            st1_step_frac <= {1'b1, st0_step_frac} >> st0_step_shift;
            st1_initial   <= st0_initial;
            st1_increment <= st0_increment;
        end
    end

    // ----------------------------------------
    // stage 2: load or accumulate
    // ----------------------------------------

    // step follows the accumulator when its exponent grows
    assign st2_step_adj = st2_step_frac >>> st2_shift;
    assign st2_inc_frac = (st2_base_frac >>> st2_shift) + st2_step_adj;

    always_ff @(posedge clk) begin
        if (stage_cke[2]) begin
            if (st1_initial) begin
                st2_base_sign <= st1_init_sign;
                st2_base_exp  <= st1_exp;
                st2_base_frac <= {2'b00, st1_init_frac};
                // step sign relative to the initial value
                st2_step_frac <= (st1_init_sign == st1_step_sign) ?
                                 {1'b0, st1_step_frac} : -{1'b0, st1_step_frac};
                st2_shift     <= 1'b0;
            end else if (st1_increment) begin
                // mantissa overflow, renormalized lazily on the next use
                st2_shift     <= (st2_inc_frac[FRAC_W+2] != st2_inc_frac[FRAC_W+1]) ||
                                 (st2_inc_frac[FRAC_W+1] && st2_inc_frac[FRAC_W:0] == '0);
                st2_base_exp  <= st2_base_exp + EXP_W'(st2_shift);
                st2_base_frac <= st2_inc_frac;
                st2_step_frac <= st2_step_adj;
            end
        end
    end

    // stage 3: back to sign and magnitude
    assign st2_norm = st2_base_frac >>> st2_shift;
    assign st2_mag  = st2_norm[FRAC_W+2] ? -st2_norm : st2_norm;

    always_ff @(posedge clk) begin
        if (stage_cke[3]) begin
            st3_sign <= st2_norm[FRAC_W+2] ? ~st2_base_sign : st2_base_sign;
            st3_exp  <= st2_base_exp + EXP_W'(st2_shift);
            st3_frac <= st2_mag[FRAC_W:0];
        end
    end

    // stage 4: leading zero count, highest set bit wins
    always_comb begin
        st3_lz = '0;
        for (int i = 0; i <= FRAC_W; i++) begin
            if (st3_frac[i]) begin
                st3_lz = EXP_W'(FRAC_W - i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_cke[4]) begin
            st4_sign  <= st3_sign;
            st4_exp   <= st3_exp;
            st4_frac  <= st3_frac;
            st4_shift <= st3_lz;
        end
    end

    // stage 5: correct for cancellation
    assign st4_norm = st4_frac << st4_shift;

    always_ff @(posedge clk) begin
        if (stage_cke[5]) begin
            st5_sign <= st4_sign;
            st5_exp  <= (st4_frac == '0) ? '0 : st4_exp - st4_shift;
            st5_frac <= st4_norm[FRAC_W-1:0];
        end
    end

    assign data = {st5_sign, st5_exp, st5_frac};

    // the sequencer never issues a load and an add together
    a_one_kind: assert property (@(posedge clk) stage_cke[0] |-> !(is_initial && is_increment))
        else $error("float_step: initial and increment both set");

endmodule

`default_nettype wire

/* float_step/stage_valid_ctrl.sv */
// per-stage valid shift register driving stage enables and the sideband delay

`default_nettype none

module stage_valid_ctrl #(
    parameter type      tag_t      = logic,
    localparam int      NUM_STAGES = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  tag_t                  in_tag,
    output logic [NUM_STAGES-1:0] stage_cke,
    output logic                  out_valid,
    output tag_t                  out_tag
);

    // valid_q[k] marks an item held in stage k
    logic [NUM_STAGES-1:0] valid_q;
    tag_t                  tag_q [NUM_STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[NUM_STAGES-2:0], in_valid};
        end
    end

    // a stage clocks only when an item arrives at it
    assign stage_cke = {valid_q[NUM_STAGES-2:0], in_valid};

    // ----------------------------------------
    // sideband follows the same enables
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (stage_cke[0]) begin
            tag_q[0] <= in_tag;
        end
        for (int k = 1; k < NUM_STAGES; k++) begin
            if (stage_cke[k]) begin
                tag_q[k] <= tag_q[k-1];
            end
        end
    end

    assign out_valid = valid_q[NUM_STAGES-1];
    assign out_tag   = tag_q[NUM_STAGES-1];

    // item and tag leave together six cycles after entering
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ($past(in_valid, NUM_STAGES) && (out_tag == $past(in_tag, NUM_STAGES))))
        else $error("stage_valid_ctrl: output does not match the input six cycles earlier");

endmodule

`default_nettype wire

/* logic/float_span_unit.sv */
// span interpolator top: registers, sequencer, stage control and channel cores

`default_nettype none

`include "raster_settings.svh"

module float_span_unit
    import float_pkg::*;
    import span_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  cfg_wr_t  cfg,
    output logic     busy,
    output pix_out_t pix
);

    logic      start;
    span_cfg_t active;
    step_cmd_t cmd;
    pix_tag_t  seq_tag;
    pix_tag_t  out_tag;
    logic      out_valid;
    logic [5:0] stage_cke;
    float_t    ch_data [`RS_NUM_CH];

    span_regs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .busy   (busy),
        .start  (start),
        .active (active)
    );

    span_sequencer u_seq (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .length (active.length),
        .cmd    (cmd),
        .tag    (seq_tag),
        .busy   (busy)
    );

    stage_valid_ctrl #(.tag_t(pix_tag_t)) u_valid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (cmd.valid),
        .in_tag    (seq_tag),
        .stage_cke (stage_cke),
        .out_valid (out_valid),
        .out_tag   (out_tag)
    );

    // one core per channel, all sharing the stage enables
    for (genvar c = 0; c < `RS_NUM_CH; c++) begin : g_ch
        float_step u_step (
            .clk          (clk),
            .stage_cke    (stage_cke),
            .init         (active.init[c]),
            .step         (active.step[c]),
            .is_initial   (cmd.is_initial),
            .is_increment (cmd.is_increment),
            .data         (ch_data[c])
        );
    end

    always_comb begin
        pix.valid = out_valid;
        pix.tag   = out_tag;
        for (int c = 0; c < `RS_NUM_CH; c++) begin
            pix.value[c] = ch_data[c];
        end
    end

endmodule

`default_nettype wire

/* logic/span_regs.sv */
// shadow and active span configuration registers with start strobe

`default_nettype none

`include "raster_settings.svh"

module span_regs
    import span_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  cfg_wr_t   cfg,
    input  logic      busy,
    output logic      start,
    output span_cfg_t active
);

    span_cfg_t shadow;
    logic      ctrl_wr;
    logic      accept;

    // ----------------------------------------
    // shadow copy, writable at any time
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (cfg.valid) begin
            if (cfg.addr == ADDR_LEN) begin
                shadow.length <= cfg.data[`RS_LEN_WIDTH-1:0];
            end
            for (int c = 0; c < `RS_NUM_CH; c++) begin
                if (cfg.addr == init_addr(c)) begin
                    shadow.init[c] <= cfg.data;
                end
                if (cfg.addr == step_addr(c)) begin
                    shadow.step[c] <= cfg.data;
                end
            end
        end
    end

    // ----------------------------------------
    // span start
    // ----------------------------------------

    // ignored while a span runs or one is just starting
    assign ctrl_wr = cfg.valid && (cfg.addr == ADDR_CTRL);
    assign accept  = ctrl_wr && !busy && !start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            active <= shadow;
        end
    end

endmodule

`default_nettype wire

/* logic/span_sequencer.sv */
// span sequencer: one load item then increment items, one per cycle

`default_nettype none

`include "raster_settings.svh"

module span_sequencer
    import span_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [`RS_LEN_WIDTH-1:0] length,
    output step_cmd_t                cmd,
    output pix_tag_t                 tag,
    output logic                     busy
);

    logic [`RS_LEN_WIDTH-1:0] last_index;

    // zero length behaves as one pixel
    always_ff @(posedge clk) begin
        if (start) begin
            last_index <= (length == '0) ? '0 : length - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd <= '0;
            tag <= '0;
        end else if (start) begin
            cmd.valid        <= 1'b1;
            cmd.is_initial   <= 1'b1;
            cmd.is_increment <= 1'b0;
            tag.index        <= '0;
            tag.last         <= (length <= 1);
        end else if (cmd.valid) begin
            if (tag.last) begin
                cmd <= '0;
            end else begin
                cmd.is_initial   <= 1'b0;
                cmd.is_increment <= 1'b1;
                tag.index        <= tag.index + 1'b1;
                tag.last         <= (tag.index + 1'b1 == last_index);
            end
        end
    end

    // busy while items are being issued
    assign busy = cmd.valid;

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("span_sequencer: start while busy");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the span interpolator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f float_span_unit.f \
    --top-module tb_float_span_unit \
    --Mdir build -o sim_tb

status=0
./build/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation passed"

/* verification/tb_float_span_unit.sv */
// span interpolator testbench with span table, float reference model, checks and timeout

`default_nettype none

`include "raster_settings.svh"

module tb_float_span_unit
    import float_pkg::*;
    import span_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int NUM_SPANS    = 5;
    // fixed cost per span on top of its pixels for writes, start and pipeline fill
    localparam int SPAN_CYCLES  = 12;

    logic     clk = 1'b0;
    logic     rst_n;
    cfg_wr_t  cfg;
    logic     busy;
    pix_out_t pix;

    int cycle = 0;
    int cycle_limit;

    // ----------------------------------------
    // span table
    // ----------------------------------------

    // partial sums are exact in single precision and never hit zero
    int  len_tab  [NUM_SPANS] = '{8, 10, 0, 12, 7};
    real init_tab [NUM_SPANS][`RS_NUM_CH] = '{
        '{1.5, 0.5}, '{2.0, -1.0}, '{3.0, -0.5}, '{-6.0, 0.125}, '{100.0, 0.8125}
    };
    real step_tab [NUM_SPANS][`RS_NUM_CH] = '{
        '{0.75, 0.25}, '{-0.75, 0.375}, '{1.0, -0.5}, '{1.25, 0.0625}, '{-12.5, -0.125}
    };

    float_span_unit DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .busy  (busy),
        .pix   (pix)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // length 0 still yields one pixel
    function automatic int pixels_of(input int r);
        return (len_tab[r] == 0) ? 1 : len_tab[r];
    endfunction

    // exact real value to single precision bits
    function automatic logic [31:0] to_float(input real v);
        logic sign;
        int   e;
        int   f;
        real  m;
        sign = (v < 0.0);
        m    = sign ? -v : v;
        e    = 127;
        if (m == 0.0) begin
            return '0;
        end
        while (m >= 2.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 1.0) begin
            m = m * 2.0;
            e--;
        end
        f = $rtoi((m - 1.0) * 8388608.0);
        return {sign, e[EXP_W-1:0], f[FRAC_W-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // ----------------------------------------
    // bus driving from the falling edge
    // ----------------------------------------

    task automatic write_reg(input logic [CFG_ADDR_W-1:0] addr,
                             input logic [CFG_DATA_W-1:0] data);
        cfg.valid = 1'b1;
        cfg.addr  = addr;
        cfg.data  = data;
        @(negedge clk);
        cfg.valid = 1'b0;
    endtask

    task automatic load_span_regs(input int r);
        write_reg(ADDR_LEN, 32'(len_tab[r]));
        for (int c = 0; c < `RS_NUM_CH; c++) begin
            write_reg(init_addr(c), to_float(init_tab[r][c]));
            write_reg(step_addr(c), to_float(step_tab[r][c]));
        end
    endtask

    task automatic run_span(input int r);
        int  n;
        int  start_cycle;
        real value;
        n           = pixels_of(r);
        start_cycle = cycle;
        write_reg(ADDR_CTRL, 32'h0);
        // next span goes into the shadow copy while this one runs
        if (r + 1 < NUM_SPANS) begin
            load_span_regs(r + 1);
        end
        // extra start while busy is dropped
        if (n >= 6) begin
            while (cycle - start_cycle < 3) begin
                @(negedge clk);
            end
            check_value("busy", 32'(busy), 32'h1);
            write_reg(ADDR_CTRL, 32'h0);
        end
        while (!pix.valid) begin
            @(negedge clk);
        end
        check_value("first pixel latency", 32'(cycle - start_cycle), 32'd8);
        for (int i = 0; i < n; i++) begin
            check_value("pix.valid", 32'(pix.valid), 32'h1);
            check_value("pix.tag.index", 32'(pix.tag.index), 32'(i));
            check_value("pix.tag.last", 32'(pix.tag.last), 32'(i == n - 1));
            for (int c = 0; c < `RS_NUM_CH; c++) begin
                value = init_tab[r][c] + i * step_tab[r][c];
                check_value($sformatf("pix.value[%0d] at pixel %0d", c, i),
                            pix.value[c], to_float(value));
            end
            @(negedge clk);
        end
        // exactly n pixels and then idle
        check_value("pix.valid", 32'(pix.valid), 32'h0);
        check_value("busy", 32'(busy), 32'h0);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        rst_n       = 1'b0;
        cfg         = '0;
        cycle_limit = RESET_CYCLES + SPAN_CYCLES * NUM_SPANS;
        for (int r = 0; r < NUM_SPANS; r++) begin
            cycle_limit += pixels_of(r);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // nothing comes out before the first start
        repeat (2) begin
            check_value("pix.valid", 32'(pix.valid), 32'h0);
            check_value("busy", 32'(busy), 32'h0);
            @(negedge clk);
        end
        load_span_regs(0);
        check_value("pix.valid", 32'(pix.valid), 32'h0);
        check_value("busy", 32'(busy), 32'h0);

        for (int r = 0; r < NUM_SPANS; r++) begin
            run_span(r);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
